// File: files.f
common/tft_pkg.sv
design/tft_fifo.sv
design/tft_wb_regs.sv
spi/tft_spi_master.sv
design/tft_spi_top.sv
tests/tft_clock_gen.sv
tests/tft_spi_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tft_spi_tb -o tft_spi_sim &&
./obj_dir/tft_spi_sim || exit 1

// File: tests/tft_spi_tb.sv
`timescale 1ns/1ps

module tft_spi_tb;

    localparam int SCLK_HALF  = tft_pkg::DEF_SCLK_HALF;
    localparam int GAP_CYCLES = tft_pkg::DEF_GAP_CYCLES;
    localparam int DEPTH      = tft_pkg::DEF_FIFO_DEPTH;
    localparam int FRAMES     = 24;   // 10 + 6 + 7 + 1 over all tests
    localparam int WD_CYCLES  = FRAMES * (32 * SCLK_HALF + GAP_CYCLES + 10) + 16 + 1000;

    logic clk, nrst, cyc, stb, we, ack, cs, sclk, mosi, miso;
    logic [1:0] adr;
    logic [15:0] dat_w, dat_r;

    tft_pkg::byte_t  resp_table [256];
    tft_pkg::frame_t exp_frames [$];
    tft_pkg::byte_t  rx_exp [$];
    logic [31:0]     rng_state = 32'd45;
    int              check_idx = 0;
    int              hi_cnt = 0;
    int              cap_bits;
    logic [15:0]     cap_frame;
    event            frame_done;

    tft_clock_gen #(.PERIOD(40), .RST_CYCLES(16)) clock_gen (.clk(clk), .nrst(nrst));

    tft_spi_top #(
        .SCLK_HALF  (SCLK_HALF),
        .GAP_CYCLES (GAP_CYCLES),
        .DEPTH      (DEPTH)
    ) tft_spi_top_inst (
        .clk(clk), .nrst(nrst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // display answers a read with the table entry at the frame's low byte
    function automatic tft_pkg::byte_t expected_byte(input tft_pkg::frame_t f);
        return resp_table[f[7:0]];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input int exp, input int act);
        assert (exp == act)
        else fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic wb_xfer(input logic wr, input logic [1:0] a, input logic [15:0] d,
                           output logic [15:0] rd, output int waited);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_w = d;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack);
        rd = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic write_frame(input tft_pkg::frame_t f, output int waited);
        logic [15:0] rd;
        wb_xfer(1'b1, tft_pkg::ADDR_TX, f, rd, waited);
        exp_frames.push_back(f);
        if (f[15:8] == tft_pkg::CMD_READ) rx_exp.push_back(expected_byte(f));
    endtask

    task automatic read_reg(input logic [1:0] a, output logic [15:0] rd);
        int waited;
        wb_xfer(1'b0, a, 16'h0000, rd, waited);
    endtask

    task automatic random_frame(input logic is_read, output tft_pkg::frame_t f);
        rng_state = lcg_next(rng_state);
        f = rng_state[31:16];
        if (is_read) f[15:8] = tft_pkg::CMD_READ;
        else if (f[15:8] == tft_pkg::CMD_READ) f[8] = ~f[8];
    endtask

    task automatic wait_idle();
        logic [15:0] st;
        do read_reg(tft_pkg::ADDR_STATUS, st);
        while (!st[tft_pkg::STAT_TX_EMPTY] || st[tft_pkg::STAT_BUSY]);
    endtask

    always @(negedge clk) begin
        if (cs === 1'b1) hi_cnt++;
        else hi_cnt = 0;
    end

    // ra8875 serial side in mode 0
    initial begin : ra8875_model
        tft_pkg::byte_t reply;
        logic           read_cmd;
        miso = 1'b0;
        forever begin
            @(negedge cs);
            assert (hi_cnt >= GAP_CYCLES)
            else fail_run("chip select was high for too few cycles between frames");
            assert (check_idx < exp_frames.size())
            else fail_run("a frame started on the pins that was never written");
            reply = expected_byte(exp_frames[check_idx]);
            read_cmd = 1'b0;
            cap_frame = '0;
            cap_bits = 0;
            while (cs == 1'b0) begin
                @(sclk or cs);
                if (cs == 1'b0 && sclk == 1'b1) begin
                    cap_frame = {cap_frame[14:0], mosi};
                    cap_bits++;
                    if (cap_bits == 8) read_cmd = (cap_frame[7:0] == tft_pkg::CMD_READ);
                end else if (cs == 1'b0 && read_cmd && cap_bits >= 8 && cap_bits < 16) begin
                    #1 miso = reply[7];
                    reply = {reply[6:0], 1'b0};
                end
            end
            miso = 1'b0;
            -> frame_done;
        end
    end

    always @(frame_done) begin
        check_equal("sclk rising edges per frame", 16, cap_bits);
        check_equal("frame on mosi", int'(exp_frames[check_idx]), int'(cap_frame));
        check_idx++;
    end

    initial begin : watchdog
        #(WD_CYCLES * 40);
        fail_run($sformatf("timeout, the run did not finish within %0d cycles", WD_CYCLES));
    end

    initial begin : main
        tft_pkg::frame_t f;
        logic [15:0]     rd;
        logic [15:0]     st_exp;
        int              waited;
        int              max_wait;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 2'd0;
        dat_w = 16'h0000;
        for (int i = 0; i < 256; i++) begin
            rng_state = lcg_next(rng_state);
            resp_table[i] = rng_state[23:16];
        end
        @(posedge nrst);

        check_equal("reset cs", 1, int'(cs));
        check_equal("reset sclk", 0, int'(sclk));
        check_equal("reset mosi", 0, int'(mosi));
        st_exp = '0;
        st_exp[tft_pkg::STAT_TX_EMPTY] = 1'b1;
        st_exp[tft_pkg::STAT_RX_EMPTY] = 1'b1;
        read_reg(tft_pkg::ADDR_STATUS, rd);
        check_equal("reset status", int'(st_exp), int'(rd));

        for (int i = 0; i < 10; i++) begin
            random_frame(1'b0, f);
            write_frame(f, waited);
        end
        wait_idle();
        read_reg(tft_pkg::ADDR_STATUS, rd);
        check_equal("rx empty after write frames", 1, int'(rd[tft_pkg::STAT_RX_EMPTY]));

        for (int i = 0; i < 6; i++) begin
            random_frame(i % 2 == 0, f);   // reads and writes interleaved
            write_frame(f, waited);
        end
        wait_idle();
        while (rx_exp.size() > 0) begin
            read_reg(tft_pkg::ADDR_RX, rd);
            check_equal("rx byte", int'({8'h00, rx_exp.pop_front()}), int'(rd));
        end
        read_reg(tft_pkg::ADDR_STATUS, rd);
        check_equal("rx empty after reads", 1, int'(rd[tft_pkg::STAT_RX_EMPTY]));

        max_wait = 0;
        for (int i = 0; i < DEPTH + 3; i++) begin
            random_frame(1'b0, f);
            write_frame(f, waited);
            if (waited > max_wait) max_wait = waited;
        end
        assert (max_wait > 1)
        else fail_run("ack never stalled while the transmit FIFO was full");
        // last stalled write refilled the queue while one frame shifts
        read_reg(tft_pkg::ADDR_STATUS, rd);
        check_equal("tx full after burst", 1, int'(rd[tft_pkg::STAT_TX_FULL]));
        wait_idle();

        read_reg(tft_pkg::ADDR_RX, rd);
        check_equal("empty rx read", 0, int'(rd));
        random_frame(1'b0, f);
        write_frame(f, waited);
        read_reg(tft_pkg::ADDR_STATUS, rd);
        check_equal("busy while shifting", 1, int'(rd[tft_pkg::STAT_BUSY]));
        wait_idle();

        check_equal("frames sent", exp_frames.size(), check_idx);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tests/tft_clock_gen.sv
`timescale 1ns/1ps

module tft_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = !clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        nrst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 nrst = 1'b1;
    end

endmodule

// File: design/tft_spi_top.sv
`timescale 1ns/1ps

module tft_spi_top #(
    parameter int SCLK_HALF  = tft_pkg::DEF_SCLK_HALF,
    parameter int GAP_CYCLES = tft_pkg::DEF_GAP_CYCLES,
    parameter int DEPTH      = tft_pkg::DEF_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        nrst,
    // wishbone slave
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [15:0] dat_w,
    output logic [15:0] dat_r,
    output logic        ack,
    // ra8875 spi
    output logic        cs,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso
);

    logic            tx_push;
    tft_pkg::frame_t tx_wdata;
    logic            tx_full;
    logic            tx_empty;
    logic            tx_pop;
    tft_pkg::frame_t tx_rdata;

    logic            rx_push;
    tft_pkg::byte_t  rx_wdata;
    logic            rx_empty;
    logic            rx_pop;
    tft_pkg::byte_t  rx_rdata;

    logic            busy;

    tft_wb_regs wb_regs (
        .clk      (clk),
        .nrst     (nrst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .tx_push  (tx_push),
        .tx_data  (tx_wdata),
        .rx_data  (rx_rdata),
        .rx_empty (rx_empty),
        .rx_pop   (rx_pop),
        .busy     (busy)
    );

    tft_fifo #(
        .payload_t (tft_pkg::frame_t),
        .DEPTH     (DEPTH)
    ) tx_fifo (
        .clk     (clk),
        .nrst    (nrst),
        .wr_en   (tx_push),
        .wr_data (tx_wdata),
        .rd_en   (tx_pop),
        .rd_data (tx_rdata),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    // a full rx queue drops the byte
    tft_fifo #(
        .payload_t (tft_pkg::byte_t),
        .DEPTH     (DEPTH)
    ) rx_fifo (
        .clk     (clk),
        .nrst    (nrst),
        .wr_en   (rx_push),
        .wr_data (rx_wdata),
        .rd_en   (rx_pop),
        .rd_data (rx_rdata),
        .full    (),
        .empty   (rx_empty)
    );

    tft_spi_master #(
        .SCLK_HALF  (SCLK_HALF),
        .GAP_CYCLES (GAP_CYCLES)
    ) spi_master (
        .clk      (clk),
        .nrst     (nrst),
        .tx_empty (tx_empty),
        .tx_data  (tx_rdata),
        .tx_pop   (tx_pop),
        .rx_push  (rx_push),
        .rx_data  (rx_wdata),
        .busy     (busy),
        .cs       (cs),
        .sclk     (sclk),
        .mosi     (mosi),
        .miso     (miso)
    );

endmodule

// File: spi/tft_spi_master.sv
`timescale 1ns/1ps

module tft_spi_master #(
    parameter int SCLK_HALF  = 2,
    parameter int GAP_CYCLES = 4
) (
    input  logic            clk,
    input  logic            nrst,
    // frame queue
    input  logic            tx_empty,
    input  tft_pkg::frame_t tx_data,
    output logic            tx_pop,
    // byte queue
    output logic            rx_push,
    output tft_pkg::byte_t  rx_data,
    output logic            busy,
    // ra8875 pins
    output logic            cs,
    output logic            sclk,
    output logic            mosi,
    input  logic            miso
);

    localparam int MAXT = (SCLK_HALF > GAP_CYCLES) ? SCLK_HALF : GAP_CYCLES;
    localparam int TW   = $clog2(MAXT + 1);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // wait for a queued frame
        SHIFT = 2'd1,   // 16 serial clocks
        GAP   = 2'd2    // cs held high between frames
    } state_t;

    state_t          state;
    logic [TW-1:0]   tick;
    logic [4:0]      bit_cnt;
    tft_pkg::frame_t shreg;
    tft_pkg::byte_t  rx_shift;
    logic            is_read;
    logic            half_done;
    logic            last_fall;

    assign tx_pop    = (state == IDLE) && !tx_empty;
    assign busy      = (state != IDLE) || tx_pop;
    assign half_done = (state == SHIFT) && (tick == TW'(SCLK_HALF - 1));
    assign last_fall = half_done && sclk && (bit_cnt == 5'd16);
    assign mosi      = shreg[15];   // msb first, moves on falling edges
    assign rx_push   = last_fall && is_read;
    assign rx_data   = rx_shift;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= IDLE;
            tick    <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            cs      <= 1'b1;
            shreg   <= '0;
            is_read <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (tx_pop) begin
                        shreg   <= tx_data;
                        is_read <= (tx_data[15:8] == tft_pkg::CMD_READ);
                        cs      <= 1'b0;
                        tick    <= '0;
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (half_done) begin
                        tick <= '0;
                        sclk <= !sclk;
                        if (!sclk) begin
                            bit_cnt <= bit_cnt + 1'b1;   // rising edge
                        end else begin
                            shreg <= shreg << 1;   // empties to zero after bit 0
                            if (last_fall) begin
                                cs    <= 1'b1;
                                state <= GAP;
                            end
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                GAP: begin
                    if (tick == TW'(GAP_CYCLES - 1)) begin
                        tick  <= '0;
                        state <= IDLE;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // sample miso on rising sclk, last 8 bits are the reply
    always_ff @(posedge clk) begin
        if (half_done && !sclk) begin
            rx_shift <= {rx_shift[6:0], miso};
        end
    end

endmodule

// File: design/tft_wb_regs.sv
`timescale 1ns/1ps

module tft_wb_regs (
    input  logic           clk,
    input  logic           nrst,
    // wishbone classic slave
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  logic [1:0]     adr,
    input  logic [15:0]    dat_w,
    output logic [15:0]    dat_r,
    output logic           ack,
    // transmit fifo write side
    input  logic           tx_full,
    input  logic           tx_empty,
    output logic           tx_push,
    output tft_pkg::frame_t tx_data,
    // receive fifo read side
    input  tft_pkg::byte_t rx_data,
    input  logic           rx_empty,
    output logic           rx_pop,
    input  logic           busy
);

    logic        req;
    logic        tx_sel;
    logic        rx_sel;
    logic        stall;
    logic        accept;
    logic [15:0] status;
    logic [15:0] rd_word;

    assign req    = cyc && stb && !ack;   // !ack keeps one ack per request
    assign tx_sel = (adr == tft_pkg::ADDR_TX);
    assign rx_sel = (adr == tft_pkg::ADDR_RX);

    // tx write waits while the frame queue is full
    assign stall  = we && tx_sel && tx_full;
    assign accept = req && !stall;

    assign tx_push = accept && we && tx_sel;
    assign tx_data = dat_w;
    assign rx_pop  = accept && !we && rx_sel && !rx_empty;

    always_comb begin
        status = '0;
        status[tft_pkg::STAT_TX_FULL]  = tx_full;
        status[tft_pkg::STAT_TX_EMPTY] = tx_empty;
        status[tft_pkg::STAT_RX_EMPTY] = rx_empty;
        status[tft_pkg::STAT_BUSY]     = busy;
    end

    always_comb begin
        rd_word = '0;
        case (adr)
            tft_pkg::ADDR_STATUS: rd_word = status;
            tft_pkg::ADDR_RX: begin
                if (!rx_empty) rd_word = {8'h00, rx_data};   // empty reads as zero
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (accept && !we) begin
            dat_r <= rd_word;
        end
    end

endmodule

// File: design/tft_fifo.sv
`timescale 1ns/1ps

module tft_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     full,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    // wraps at DEPTH, so depth need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr   = wr_en && !full;   // overflow ignored
    assign do_rd   = rd_en && !empty;
    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];       // head always visible

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= next_ptr(wr_ptr);
            if (do_rd) rd_ptr <= next_ptr(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: common/tft_pkg.sv
package tft_pkg;

    // one spi frame: command or register byte on top, data byte below
    typedef logic [15:0] frame_t;
    typedef logic [7:0]  byte_t;

    // ra8875 read-data command prefix
    localparam byte_t CMD_READ = 8'h40;

    // wishbone word addresses
    localparam logic [1:0] ADDR_TX     = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;
    localparam logic [1:0] ADDR_RX     = 2'd2;

    // status word bits
    localparam int STAT_TX_FULL  = 0;
    localparam int STAT_TX_EMPTY = 1;
    localparam int STAT_RX_EMPTY = 2;
    localparam int STAT_BUSY     = 3;

    // defaults for the top level
    localparam int DEF_SCLK_HALF   = 2;
    localparam int DEF_GAP_CYCLES  = 4;
    localparam int DEF_FIFO_DEPTH  = 4;

endpackage
